// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= eth_rx_tb
FILELIST  ?= eth_rx.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^sim passed$$'

clean:
	rm -rf $(BUILD_DIR)

// ==== eth_rx.f ====
src/eth_rx_pkg.sv
src/eth_byte_if.sv
src/gmii_frame_rx.sv
src/ethertype_decoder.sv
src/rx_frame_fifo.sv
src/eth_rx_ctrl.sv
src/eth_rx_top.sv
verif/eth_rx_assert.sv
verif/eth_rx_tb.sv

// ==== src/eth_byte_if.sv ====
`timescale 1ns/1ps
// Byte stream between the receive stages, one byte per valid cycle
interface eth_byte_if;
	import eth_rx_pkg::*;

	logic [7:0] data;
	logic       valid;
	// Marks the first byte after the SFD
	logic       first;
	logic       last;
	// Only looked at together with last
	rx_drop_e   cause;

	// No ready, the line side cannot be stalled
	modport src (output data, valid, first, last, cause);
	modport snk (input data, valid, first, last, cause);

endinterface

// ==== src/eth_rx_ctrl.sv ====
`timescale 1ns/1ps
module eth_rx_ctrl (
	input  logic                               clk_fabric,
	input  logic                               rst_n,
	input  logic [eth_rx_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr,
	input  logic                               s_axil_awvalid,
	output logic                               s_axil_awready,
	input  logic [31:0]                        s_axil_wdata,
	input  logic [3:0]                         s_axil_wstrb,
	input  logic                               s_axil_wvalid,
	output logic                               s_axil_wready,
	output logic [1:0]                         s_axil_bresp,
	output logic                               s_axil_bvalid,
	input  logic                               s_axil_bready,
	input  logic [eth_rx_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
	input  logic                               s_axil_arvalid,
	output logic                               s_axil_arready,
	output logic [31:0]                        s_axil_rdata,
	output logic [1:0]                         s_axil_rresp,
	output logic                               s_axil_rvalid,
	input  logic                               s_axil_rready,
	output logic                               rx_enable,
	output logic [47:0]                        our_mac,
	output logic                               promisc,
	input  logic                               frame_done,
	input  eth_rx_pkg::rx_drop_e               frame_cause
);
	import eth_rx_pkg::*;

	logic [31:0] rx_ok;
	logic [31:0] rx_drop;
	rx_drop_e    last_cause;
	logic [31:0] ctrl_wr;
	logic [31:0] lo_wr;
	logic [31:0] hi_wr;
	logic [31:0] rd_word;

	// Byte lanes of a write merged onto the current value
	function automatic logic [31:0] apply_strb(input logic [31:0] cur, input logic [31:0] wd,
		input logic [3:0] strb);
		logic [31:0] res;
		res = cur;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[8*i +: 8] = wd[8*i +: 8];
		end
		return res;
	endfunction

	assign ctrl_wr = apply_strb({30'd0, promisc, rx_enable}, s_axil_wdata, s_axil_wstrb);
	assign lo_wr   = apply_strb(our_mac[31:0], s_axil_wdata, s_axil_wstrb);
	assign hi_wr   = apply_strb({16'd0, our_mac[47:32]}, s_axil_wdata, s_axil_wstrb);

	// Always OKAY
	assign s_axil_bresp = 2'b00;
	assign s_axil_rresp = 2'b00;

	always_comb begin
		case (s_axil_araddr)
			REG_CTRL:       rd_word = {30'd0, promisc, rx_enable};
			REG_MAC_LO:     rd_word = our_mac[31:0];
			REG_MAC_HI:     rd_word = {16'd0, our_mac[47:32]};
			REG_RX_OK:      rd_word = rx_ok;
			REG_RX_DROP:    rd_word = rx_drop;
			REG_LAST_CAUSE: rd_word = {29'd0, last_cause};
			default:        rd_word = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Write channel and config registers

	always_ff @(posedge clk_fabric) begin
		if (!rst_n) begin
			s_axil_awready <= 1'b0;
			s_axil_wready  <= 1'b0;
			s_axil_bvalid  <= 1'b0;
			rx_enable      <= 1'b1;
			promisc        <= 1'b0;
			our_mac        <= '0;
		end else begin
			// Ready pulse once both address and data are offered
			s_axil_awready <= s_axil_awvalid && s_axil_wvalid && !s_axil_awready &&
				!s_axil_bvalid;
			s_axil_wready  <= s_axil_awvalid && s_axil_wvalid && !s_axil_awready &&
				!s_axil_bvalid;
			if (s_axil_awready && s_axil_awvalid) begin
				s_axil_bvalid <= 1'b1;
				case (s_axil_awaddr)
					REG_CTRL: begin
						rx_enable <= ctrl_wr[0];
						promisc   <= ctrl_wr[1];
					end
					REG_MAC_LO: our_mac[31:0]  <= lo_wr;
					REG_MAC_HI: our_mac[47:32] <= hi_wr[15:0];
					default: ;
				endcase
			end else if (s_axil_bready) begin
				s_axil_bvalid <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Read channel and frame counters

	always_ff @(posedge clk_fabric) begin
		if (!rst_n) begin
			s_axil_arready <= 1'b0;
			s_axil_rvalid  <= 1'b0;
			rx_ok          <= '0;
			rx_drop        <= '0;
			last_cause     <= DROP_NONE;
		end else begin
			s_axil_arready <= s_axil_arvalid && !s_axil_arready && !s_axil_rvalid;
			if (s_axil_arready && s_axil_arvalid)
				s_axil_rvalid <= 1'b1;
			else if (s_axil_rready)
				s_axil_rvalid <= 1'b0;
			// Accepted and dropped frames, last cause only on drops
			if (frame_done && frame_cause == DROP_NONE) begin
				rx_ok <= rx_ok + 32'd1;
			end else if (frame_done) begin
				rx_drop    <= rx_drop + 32'd1;
				last_cause <= frame_cause;
			end
		end
	end

	// Read data, captured on the address handshake
	always_ff @(posedge clk_fabric) begin
		if (s_axil_arready && s_axil_arvalid)
			s_axil_rdata <= rd_word;
	end

endmodule

// ==== src/eth_rx_pkg.sv ====
package eth_rx_pkg;

	// Ethertypes the decoder knows by name
	typedef enum logic [15:0] {
		ETH_IPV4 = 16'h0800,
		ETH_ARP  = 16'h0806,
		ETH_IPV6 = 16'h86dd
	} ethertype_e;

	// Bytes 12..13 of the header, as a type or as a length
	typedef union packed {
		ethertype_e  etype;
		logic [15:0] len;
	} type_len_u;

	// Reason a frame did not reach the output
	typedef enum logic [2:0] {
		DROP_NONE,
		DROP_GMII_ERR,
		DROP_RUNT,
		DROP_ADDR,
		DROP_BAD_LEN,
		DROP_OVERFLOW
	} rx_drop_e;

	// Framing
	localparam logic [7:0]  ETH_PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0]  ETH_SFD_BYTE      = 8'hd5;
	localparam logic [15:0] ETH_MAX_LEN       = 16'd1500;
	localparam logic [15:0] ETH_MIN_TYPE      = 16'd1536;
	localparam int          ETH_HDR_BYTES     = 14;

	// Register map, byte offsets
	localparam int AXIL_ADDR_W = 5;
	localparam logic [AXIL_ADDR_W-1:0] REG_CTRL       = 5'h00;
	localparam logic [AXIL_ADDR_W-1:0] REG_MAC_LO     = 5'h04;
	localparam logic [AXIL_ADDR_W-1:0] REG_MAC_HI     = 5'h08;
	localparam logic [AXIL_ADDR_W-1:0] REG_RX_OK      = 5'h0c;
	localparam logic [AXIL_ADDR_W-1:0] REG_RX_DROP    = 5'h10;
	localparam logic [AXIL_ADDR_W-1:0] REG_LAST_CAUSE = 5'h14;

endpackage

// ==== src/eth_rx_top.sv ====
`timescale 1ns/1ps
module eth_rx_top #(
	parameter int FIFO_DEPTH = 512
) (
	input  logic                               clk_fabric,
	input  logic                               rst_n,
	input  logic                               gmii_en,
	input  logic                               gmii_er,
	input  logic [7:0]                         gmii_data,
	output logic [7:0]                         m_data,
	output logic                               m_last,
	output logic                               m_valid,
	input  logic                               m_ready,
	input  logic [eth_rx_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr,
	input  logic                               s_axil_awvalid,
	output logic                               s_axil_awready,
	input  logic [31:0]                        s_axil_wdata,
	input  logic [3:0]                         s_axil_wstrb,
	input  logic                               s_axil_wvalid,
	output logic                               s_axil_wready,
	output logic [1:0]                         s_axil_bresp,
	output logic                               s_axil_bvalid,
	input  logic                               s_axil_bready,
	input  logic [eth_rx_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
	input  logic                               s_axil_arvalid,
	output logic                               s_axil_arready,
	output logic [31:0]                        s_axil_rdata,
	output logic [1:0]                         s_axil_rresp,
	output logic                               s_axil_rvalid,
	input  logic                               s_axil_rready
);
	import eth_rx_pkg::*;

	logic        rx_enable;
	logic        promisc;
	logic [47:0] our_mac;
	logic        frame_done;
	rx_drop_e    frame_cause;

	// After framing, then after filtering
	eth_byte_if framed_bus ();
	eth_byte_if filtered_bus ();

	//////////////////////////////////////////////////
	// Datapath

	gmii_frame_rx u_framer (
		.clk_fabric (clk_fabric),
		.rst_n      (rst_n),
		.gmii_en    (gmii_en),
		.gmii_er    (gmii_er),
		.gmii_data  (gmii_data),
		.rx_enable  (rx_enable),
		.out        (framed_bus.src)
	);

	ethertype_decoder u_decoder (
		.clk_fabric (clk_fabric),
		.rst_n      (rst_n),
		.in         (framed_bus.snk),
		.out        (filtered_bus.src),
		.our_mac    (our_mac),
		.promisc    (promisc)
	);

	rx_frame_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_fabric  (clk_fabric),
		.rst_n       (rst_n),
		.in          (filtered_bus.snk),
		.m_data      (m_data),
		.m_last      (m_last),
		.m_valid     (m_valid),
		.m_ready     (m_ready),
		.frame_done  (frame_done),
		.frame_cause (frame_cause)
	);

	// Register slave and counters
	eth_rx_ctrl u_ctrl (
		.clk_fabric     (clk_fabric),
		.rst_n          (rst_n),
		.s_axil_awaddr  (s_axil_awaddr),
		.s_axil_awvalid (s_axil_awvalid),
		.s_axil_awready (s_axil_awready),
		.s_axil_wdata   (s_axil_wdata),
		.s_axil_wstrb   (s_axil_wstrb),
		.s_axil_wvalid  (s_axil_wvalid),
		.s_axil_wready  (s_axil_wready),
		.s_axil_bresp   (s_axil_bresp),
		.s_axil_bvalid  (s_axil_bvalid),
		.s_axil_bready  (s_axil_bready),
		.s_axil_araddr  (s_axil_araddr),
		.s_axil_arvalid (s_axil_arvalid),
		.s_axil_arready (s_axil_arready),
		.s_axil_rdata   (s_axil_rdata),
		.s_axil_rresp   (s_axil_rresp),
		.s_axil_rvalid  (s_axil_rvalid),
		.s_axil_rready  (s_axil_rready),
		.rx_enable      (rx_enable),
		.our_mac        (our_mac),
		.promisc        (promisc),
		.frame_done     (frame_done),
		.frame_cause    (frame_cause)
	);

endmodule

// ==== src/ethertype_decoder.sv ====
`timescale 1ns/1ps
module ethertype_decoder (
	input  logic        clk_fabric,
	input  logic        rst_n,
	eth_byte_if.snk     in,
	eth_byte_if.src     out,
	input  logic [47:0] our_mac,
	input  logic        promisc
);
	import eth_rx_pkg::*;

	// Bytes seen so far in the frame, saturating
	logic [3:0]  bcnt;
	logic [3:0]  idx;
	logic [47:0] dst_q;
	logic [47:0] dst_d;
	type_len_u   tl_q;
	type_len_u   tl_d;
	logic        addr_ok;
	logic        len_form;
	logic        type_form;
	rx_drop_e    cause_d;

	//////////////////////////////////////////////////
	// Header capture, including the current byte

	always_comb begin
		idx   = in.first ? 4'd0 : bcnt;
		dst_d = dst_q;
		tl_d  = tl_q;
		// Destination MAC, first byte on the wire is the top octet
		if (idx < 4'd6)
			dst_d = {dst_q[39:0], in.data};
		if (idx == 4'd12)
			tl_d.len = {in.data, tl_q.len[7:0]};
		if (idx == 4'd13)
			tl_d.len = {tl_q.len[15:8], in.data};
	end

	assign addr_ok   = promisc || (dst_d == our_mac) || (dst_d == 48'hffff_ffff_ffff);
	// 802.3 length form
	assign len_form  = tl_d.len <= ETH_MAX_LEN;
	// Ethernet II type form
	assign type_form = tl_d.etype >= ETH_MIN_TYPE;

	// Cause from upstream wins, then runt, address, length
	always_comb begin
		if (in.cause != DROP_NONE)
			cause_d = in.cause;
		else if (int'(idx) < ETH_HDR_BYTES - 1)
			cause_d = DROP_RUNT;
		else if (!addr_ok)
			cause_d = DROP_ADDR;
		else if (!len_form && !type_form)
			cause_d = DROP_BAD_LEN;
		else
			cause_d = DROP_NONE;
	end

	//////////////////////////////////////////////////
	// Pipeline register

	always_ff @(posedge clk_fabric) begin
		if (!rst_n) begin
			bcnt      <= '0;
			out.valid <= 1'b0;
			out.first <= 1'b0;
			out.last  <= 1'b0;
			out.cause <= DROP_NONE;
		end else begin
			out.valid <= in.valid;
			out.first <= in.valid && in.first;
			out.last  <= in.valid && in.last;
			out.cause <= cause_d;
			if (in.valid)
				bcnt <= (idx == 4'hf) ? idx : idx + 4'd1;
		end
	end

	// Header fields and data byte
	always_ff @(posedge clk_fabric) begin
		if (in.valid) begin
			dst_q <= dst_d;
			tl_q  <= tl_d;
		end
		out.data <= in.data;
	end

endmodule

// ==== src/gmii_frame_rx.sv ====
`timescale 1ns/1ps
module gmii_frame_rx (
	input  logic       clk_fabric,
	input  logic       rst_n,
	input  logic       gmii_en,
	input  logic       gmii_er,
	input  logic [7:0] gmii_data,
	input  logic       rx_enable,
	eth_byte_if.src    out
);
	import eth_rx_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_DATA,
		ST_DISCARD
	} state_e;

	state_e     state;
	// FCS delay line, newest byte in slot 0
	logic [7:0] dly [0:3];
	// Oldest byte, sent once its successor shows up or en drops
	logic [7:0] hold_byte;
	logic [2:0] fill;
	logic       err_seen;
	logic       first_pend;
	logic       emit;

	// Line plus hold register full means a frame byte is ready
	assign emit = (state == ST_DATA) && (fill == 3'd5);

	//////////////////////////////////////////////////
	// Framing FSM

	always_ff @(posedge clk_fabric) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			fill       <= '0;
			err_seen   <= 1'b0;
			first_pend <= 1'b0;
			out.valid  <= 1'b0;
			out.first  <= 1'b0;
			out.last   <= 1'b0;
			out.cause  <= DROP_NONE;
		end else begin
			out.valid <= emit;
			out.first <= emit && first_pend;
			// En low in data state ends the frame on the held byte
			out.last  <= emit && !gmii_en;
			out.cause <= err_seen ? DROP_GMII_ERR : DROP_NONE;
			if (emit)
				first_pend <= 1'b0;
			case (state)
				ST_IDLE: begin
					fill       <= '0;
					first_pend <= 1'b1;
					err_seen   <= gmii_en && gmii_er;
					// Disabled receiver skips the frame to its end
					if (gmii_en)
						state <= (rx_enable && gmii_data == ETH_PREAMBLE_BYTE) ?
							ST_PREAMBLE : ST_DISCARD;
				end
				ST_PREAMBLE: begin
					err_seen <= err_seen || gmii_er;
					if (!gmii_en)
						state <= ST_IDLE;
					else if (gmii_data == ETH_SFD_BYTE)
						state <= ST_DATA;
					else if (gmii_data != ETH_PREAMBLE_BYTE)
						state <= ST_DISCARD;
				end
				ST_DATA: begin
					if (gmii_en) begin
						err_seen <= err_seen || gmii_er;
						if (fill != 3'd5)
							fill <= fill + 3'd1;
					end else begin
						// Bytes left in the line are the FCS
						state <= ST_IDLE;
					end
				end
				default: begin
					if (!gmii_en)
						state <= ST_IDLE;
				end
			endcase
		end
	end

	// Delay line, no reset needed
	always_ff @(posedge clk_fabric) begin
		if (state == ST_DATA && gmii_en) begin
			dly[0]    <= gmii_data;
			dly[1]    <= dly[0];
			dly[2]    <= dly[1];
			dly[3]    <= dly[2];
			hold_byte <= dly[3];
		end
		out.data <= hold_byte;
	end

endmodule

// ==== src/rx_frame_fifo.sv ====
`timescale 1ns/1ps
module rx_frame_fifo #(
	parameter int FIFO_DEPTH = 512
) (
	input  logic                 clk_fabric,
	input  logic                 rst_n,
	eth_byte_if.snk              in,
	output logic [7:0]           m_data,
	output logic                 m_last,
	output logic                 m_valid,
	input  logic                 m_ready,
	output logic                 frame_done,
	output eth_rx_pkg::rx_drop_e frame_cause
);
	import eth_rx_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	// Word is {last, data}
	logic [8:0]  mem [0:FIFO_DEPTH-1];
	// Extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] cmt_ptr;
	logic [AW:0] rd_ptr;
	logic        full;
	logic        ovf;
	logic        ovf_now;
	logic        pop;

	assign full    = (wr_ptr - rd_ptr) == (AW+1)'(FIFO_DEPTH);
	assign ovf_now = ovf || full;

	//////////////////////////////////////////////////
	// Write side

	always_ff @(posedge clk_fabric) begin
		if (in.valid && !full)
			mem[wr_ptr[AW-1:0]] <= {in.last, in.data};
	end

	always_ff @(posedge clk_fabric) begin
		if (!rst_n) begin
			wr_ptr      <= '0;
			cmt_ptr     <= '0;
			ovf         <= 1'b0;
			frame_done  <= 1'b0;
			frame_cause <= DROP_NONE;
		end else begin
			frame_done <= in.valid && in.last;
			if (in.valid && in.last) begin
				ovf <= 1'b0;
				if (in.cause == DROP_NONE && !ovf_now) begin
					// Commit the whole frame including this byte
					wr_ptr      <= wr_ptr + 1'b1;
					cmt_ptr     <= wr_ptr + 1'b1;
					frame_cause <= DROP_NONE;
				end else begin
					// Rewind, frame never becomes visible
					wr_ptr      <= cmt_ptr;
					frame_cause <= (in.cause != DROP_NONE) ? in.cause : DROP_OVERFLOW;
				end
			end else if (in.valid) begin
				if (full)
					ovf <= 1'b1;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Read side, committed words only

	assign pop = (rd_ptr != cmt_ptr) && (!m_valid || m_ready);

	always_ff @(posedge clk_fabric) begin
		if (!rst_n) begin
			rd_ptr  <= '0;
			m_valid <= 1'b0;
		end else if (pop) begin
			rd_ptr  <= rd_ptr + 1'b1;
			m_valid <= 1'b1;
		end else if (m_ready) begin
			m_valid <= 1'b0;
		end
	end

	// Output byte holds until it is taken
	always_ff @(posedge clk_fabric) begin
		if (pop)
			{m_last, m_data} <= mem[rd_ptr[AW-1:0]];
	end

endmodule

// ==== verif/eth_rx_assert.sv ====
`timescale 1ns/1ps
module eth_rx_assert (
	input logic        clk_fabric,
	input logic        rst_n,
	input logic        m_valid,
	input logic        m_ready,
	input logic [7:0]  m_data,
	input logic        m_last,
	input logic        bvalid,
	input logic        bready,
	input logic        rvalid,
	input logic        rready,
	input logic [31:0] rdata,
	input logic        awready,
	input logic        wready,
	input logic        arready
);

	// Output byte parked until taken
	a_out_hold: assert property (@(posedge clk_fabric) disable iff (!rst_n)
		m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last))
		else $error("stream output changed before m_ready");

	a_b_hold: assert property (@(posedge clk_fabric) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_r_hold: assert property (@(posedge clk_fabric) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid or rdata changed before rready");

	// First cycle out of reset
	a_reset_idle: assert property (@(posedge clk_fabric)
		$rose(rst_n) |-> !m_valid && !bvalid && !rvalid && !awready && !wready && !arready)
		else $error("handshake output high right after reset");

endmodule

bind eth_rx_top eth_rx_assert u_assert (
	.clk_fabric (clk_fabric),
	.rst_n      (rst_n),
	.m_valid    (m_valid),
	.m_ready    (m_ready),
	.m_data     (m_data),
	.m_last     (m_last),
	.bvalid     (s_axil_bvalid),
	.bready     (s_axil_bready),
	.rvalid     (s_axil_rvalid),
	.rready     (s_axil_rready),
	.rdata      (s_axil_rdata),
	.awready    (s_axil_awready),
	.wready     (s_axil_wready),
	.arready    (s_axil_arready)
);

// ==== verif/eth_rx_tb.sv ====
`timescale 1ns/1ps
module eth_rx_tb;
	import eth_rx_pkg::*;

	localparam int          FIFO_DEPTH   = 512;
	localparam int          NUM_TESTS    = 12;
	localparam int          WAIT_LIMIT   = 4000;
	localparam int          POLL_LIMIT   = 200;
	localparam int          QUIET_CYCLES = 40;
	localparam int          IDLE_GAP     = 12;
	localparam logic [47:0] OUR_MAC      = 48'h02_1a_2b_3c_4d_5e;
	localparam logic [47:0] OTHER_MAC    = 48'h02_99_88_77_66_55;
	localparam logic [47:0] SRC_MAC      = 48'h02_00_00_00_00_01;
	// AXI4-Lite OKAY
	localparam logic [1:0]  RESP_OKAY    = 2'b00;

	typedef enum {DST_OURS, DST_BCAST, DST_OTHER} dst_kind_e;

	typedef struct {
		string       name;
		dst_kind_e   dst;
		logic [15:0] type_len;
		// Bytes from destination to end of payload
		int          frame_len;
		bit          inject_er;
		bit          hold_ready;
		// Bit 0 enable, bit 1 promisc
		logic [1:0]  ctrl;
		rx_drop_e    exp_cause;
	} test_row_t;

	logic                   clk_fabric = 1'b0;
	logic                   rst_n = 1'b0;
	logic                   gmii_en = 1'b0;
	logic                   gmii_er = 1'b0;
	logic [7:0]             gmii_data = 8'h00;
	logic [7:0]             m_data;
	logic                   m_last;
	logic                   m_valid;
	logic                   m_ready = 1'b0;
	logic [AXIL_ADDR_W-1:0] s_axil_awaddr = '0;
	logic                   s_axil_awvalid = 1'b0;
	logic                   s_axil_awready;
	logic [31:0]            s_axil_wdata = '0;
	logic [3:0]             s_axil_wstrb = '0;
	logic                   s_axil_wvalid = 1'b0;
	logic                   s_axil_wready;
	logic [1:0]             s_axil_bresp;
	logic                   s_axil_bvalid;
	logic                   s_axil_bready = 1'b0;
	logic [AXIL_ADDR_W-1:0] s_axil_araddr = '0;
	logic                   s_axil_arvalid = 1'b0;
	logic                   s_axil_arready;
	logic [31:0]            s_axil_rdata;
	logic [1:0]             s_axil_rresp;
	logic                   s_axil_rvalid;
	logic                   s_axil_rready = 1'b0;

	test_row_t  tests [NUM_TESTS];
	logic [7:0] frame_q [$];
	// Expected output words {last, data} and the test each belongs to
	logic [8:0] exp_q [$];
	string      exp_name_q [$];
	logic [31:0] lfsr = 32'hb331_55d9;
	bit         ready_req = 1'b1;
	int         err_count = 0;
	int         check_count = 0;

	always #2 clk_fabric = ~clk_fabric;

	eth_rx_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_dut (
		.clk_fabric     (clk_fabric),
		.rst_n          (rst_n),
		.gmii_en        (gmii_en),
		.gmii_er        (gmii_er),
		.gmii_data      (gmii_data),
		.m_data         (m_data),
		.m_last         (m_last),
		.m_valid        (m_valid),
		.m_ready        (m_ready),
		.s_axil_awaddr  (s_axil_awaddr),
		.s_axil_awvalid (s_axil_awvalid),
		.s_axil_awready (s_axil_awready),
		.s_axil_wdata   (s_axil_wdata),
		.s_axil_wstrb   (s_axil_wstrb),
		.s_axil_wvalid  (s_axil_wvalid),
		.s_axil_wready  (s_axil_wready),
		.s_axil_bresp   (s_axil_bresp),
		.s_axil_bvalid  (s_axil_bvalid),
		.s_axil_bready  (s_axil_bready),
		.s_axil_araddr  (s_axil_araddr),
		.s_axil_arvalid (s_axil_arvalid),
		.s_axil_arready (s_axil_arready),
		.s_axil_rdata   (s_axil_rdata),
		.s_axil_rresp   (s_axil_rresp),
		.s_axil_rvalid  (s_axil_rvalid),
		.s_axil_rready  (s_axil_rready)
	);

	//////////////////////////////////////////////////
	// Compare tasks

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s: data expected 0x%02h, got 0x%02h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s: expected %b, got %b", name, exp, act);
		end
	endtask

	task automatic check_cause(input string name, input rx_drop_e exp, input rx_drop_e act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s: cause expected %s, got %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s: expected 0x%08h, got 0x%08h", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s: response expected %b, got %b", name, exp, act);
		end
	endtask

	task automatic timeout_abort(input string what);
		$display("timeout while waiting for %s", what);
		$display("sim failed");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// Payload generator

	// Galois form, one step per bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = 8'h00;
		for (int k = 0; k < 8; k++) begin
			b    = {b[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Header then LFSR payload, cut at frame_len
	task automatic build_frame(input test_row_t row);
		logic [47:0] dst;
		logic [7:0]  hdr [0:13];
		logic [7:0]  b;
		case (row.dst)
			DST_OURS:  dst = OUR_MAC;
			DST_BCAST: dst = '1;
			default:   dst = OTHER_MAC;
		endcase
		for (int k = 0; k < 6; k++) begin
			hdr[k]     = dst[47-8*k -: 8];
			hdr[6 + k] = SRC_MAC[47-8*k -: 8];
		end
		hdr[12] = row.type_len[15:8];
		hdr[13] = row.type_len[7:0];
		frame_q.delete();
		for (int k = 0; k < row.frame_len; k++) begin
			if (k < ETH_HDR_BYTES)
				b = hdr[k];
			else
				rand_byte(b);
			frame_q.push_back(b);
		end
	endtask

	//////////////////////////////////////////////////
	// GMII and AXI4-Lite drivers

	task automatic drive_gmii(input logic en, input logic er, input logic [7:0] d);
		@(negedge clk_fabric);
		gmii_en   = en;
		gmii_er   = er;
		gmii_data = d;
	endtask

	// Preamble, SFD, frame, zero FCS, then idle gap
	task automatic send_frame(input int er_at);
		for (int k = 0; k < 7; k++)
			drive_gmii(1'b1, 1'b0, ETH_PREAMBLE_BYTE);
		drive_gmii(1'b1, 1'b0, ETH_SFD_BYTE);
		for (int k = 0; k < frame_q.size(); k++)
			drive_gmii(1'b1, k == er_at, frame_q[k]);
		for (int k = 0; k < 4; k++)
			drive_gmii(1'b1, 1'b0, 8'h00);
		for (int k = 0; k < IDLE_GAP; k++)
			drive_gmii(1'b0, 1'b0, 8'h00);
	endtask

	task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data);
		int n;
		@(negedge clk_fabric);
		s_axil_awaddr  = addr;
		s_axil_awvalid = 1'b1;
		s_axil_wdata   = data;
		s_axil_wstrb   = 4'hf;
		s_axil_wvalid  = 1'b1;
		n = 0;
		while (!s_axil_awready && n < WAIT_LIMIT) begin
			@(negedge clk_fabric);
			n++;
		end
		if (!s_axil_awready)
			timeout_abort("AXI write address handshake");
		// Address and data taken in the same cycle
		check_flag($sformatf("write 0x%02h wready", addr), 1'b1, s_axil_wready);
		// Handshake lands on the coming rising edge
		@(negedge clk_fabric);
		s_axil_awvalid = 1'b0;
		s_axil_wvalid  = 1'b0;
		n = 0;
		while (!s_axil_bvalid && n < WAIT_LIMIT) begin
			@(negedge clk_fabric);
			n++;
		end
		if (!s_axil_bvalid)
			timeout_abort("AXI write response");
		check_resp($sformatf("write 0x%02h bresp", addr), RESP_OKAY, s_axil_bresp);
		// Response kept waiting for a cycle before it is taken
		@(negedge clk_fabric);
		s_axil_bready = 1'b1;
		@(negedge clk_fabric);
		s_axil_bready = 1'b0;
	endtask

	task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, output logic [31:0] data);
		int n;
		@(negedge clk_fabric);
		s_axil_araddr  = addr;
		s_axil_arvalid = 1'b1;
		n = 0;
		while (!s_axil_arready && n < WAIT_LIMIT) begin
			@(negedge clk_fabric);
			n++;
		end
		if (!s_axil_arready)
			timeout_abort("AXI read address handshake");
		@(negedge clk_fabric);
		s_axil_arvalid = 1'b0;
		n = 0;
		while (!s_axil_rvalid && n < WAIT_LIMIT) begin
			@(negedge clk_fabric);
			n++;
		end
		if (!s_axil_rvalid)
			timeout_abort("AXI read data");
		check_resp($sformatf("read 0x%02h rresp", addr), RESP_OKAY, s_axil_rresp);
		data = s_axil_rdata;
		// Read data kept waiting for a cycle before it is taken
		@(negedge clk_fabric);
		s_axil_rready = 1'b1;
		@(negedge clk_fabric);
		s_axil_rready = 1'b0;
	endtask

	// Poll a counter register until it reaches the target
	task automatic wait_counter(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] target);
		logic [31:0] rd;
		int          polls;
		polls = 0;
		axil_read(addr, rd);
		while (rd != target && polls < POLL_LIMIT) begin
			axil_read(addr, rd);
			polls++;
		end
		if (rd != target)
			timeout_abort($sformatf("counter at 0x%02h to reach %0d", addr, target));
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
			@(negedge clk_fabric);
			n++;
		end
		if (exp_q.size() != 0)
			timeout_abort("expected output bytes");
	endtask

	//////////////////////////////////////////////////
	// Output monitor

	// m_ready set here, so the byte seen now transfers on the next rising edge
	always @(negedge clk_fabric) begin : collect
		logic [8:0] word;
		string      nm;
		m_ready = ready_req;
		if (m_valid && m_ready) begin
			if (exp_q.size() == 0) begin
				err_count++;
				$display("output byte 0x%02h arrived when no frame was expected", m_data);
			end else begin
				word = exp_q.pop_front();
				nm   = exp_name_q.pop_front();
				check_byte(nm, word[7:0], m_data);
				check_flag({nm, " last"}, word[8], m_last);
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		test_row_t   row;
		logic [31:0] rd;
		logic [1:0]  cur_ctrl;
		int          errs_before;
		int          ok_exp;
		int          drop_exp;
		int          drop_rows;
		int          quiet;

		tests[0]  = '{"ipv4_ours", DST_OURS, 16'h0800, 64, 1'b0, 1'b0, 2'b01, DROP_NONE};
		tests[1]  = '{"arp_bcast", DST_BCAST, 16'h0806, 60, 1'b0, 1'b0, 2'b01, DROP_NONE};
		tests[2]  = '{"other_addr", DST_OTHER, 16'h86dd, 80, 1'b0, 1'b0, 2'b01, DROP_ADDR};
		tests[3]  = '{"other_promisc", DST_OTHER, 16'h86dd, 80, 1'b0, 1'b0, 2'b11, DROP_NONE};
		tests[4]  = '{"len_100", DST_OURS, 16'h0064, 114, 1'b0, 1'b0, 2'b01, DROP_NONE};
		tests[5]  = '{"len_1510", DST_OURS, 16'h05e6, 64, 1'b0, 1'b0, 2'b01, DROP_BAD_LEN};
		tests[6]  = '{"runt_10", DST_OURS, 16'h0800, 10, 1'b0, 1'b0, 2'b01, DROP_RUNT};
		tests[7]  = '{"gmii_err", DST_OURS, 16'h0800, 64, 1'b1, 1'b0, 2'b01, DROP_GMII_ERR};
		tests[8]  = '{"rx_off", DST_OURS, 16'h0800, 64, 1'b0, 1'b0, 2'b00, DROP_NONE};
		// 300 bytes queued, the next 300 cannot fit behind them
		tests[9]  = '{"held_fits", DST_OURS, 16'h0800, 300, 1'b0, 1'b1, 2'b01, DROP_NONE};
		tests[10] = '{"held_ovf", DST_OURS, 16'h0800, 300, 1'b0, 1'b1, 2'b01, DROP_OVERFLOW};
		tests[11] = '{"drain", DST_OURS, 16'h0800, 64, 1'b0, 1'b0, 2'b01, DROP_NONE};

		ok_exp    = 0;
		drop_exp  = 0;
		drop_rows = 0;
		cur_ctrl  = 2'b01;
		repeat (8) @(negedge clk_fabric);
		rst_n = 1'b1;

		axil_write(REG_MAC_LO, OUR_MAC[31:0]);
		axil_write(REG_MAC_HI, {16'd0, OUR_MAC[47:32]});

		for (int i = 0; i < NUM_TESTS; i++) begin
			row         = tests[i];
			errs_before = err_count;
			if (row.exp_cause != DROP_NONE)
				drop_rows++;
			if (row.ctrl != cur_ctrl) begin
				axil_write(REG_CTRL, {30'd0, row.ctrl});
				cur_ctrl = row.ctrl;
			end
			ready_req = !row.hold_ready;
			build_frame(row);
			// Only accepted frames leave the DUT
			if (row.ctrl[0] && row.exp_cause == DROP_NONE) begin
				ok_exp++;
				for (int k = 0; k < frame_q.size(); k++) begin
					exp_q.push_back({k == frame_q.size() - 1, frame_q[k]});
					exp_name_q.push_back(row.name);
				end
			end else if (row.ctrl[0]) begin
				drop_exp++;
			end
			send_frame(row.inject_er ? 20 : -1);

			if (!row.ctrl[0]) begin
				// Disabled receiver, watch a window longer than the pipeline
				quiet = 0;
				while (quiet < QUIET_CYCLES && !m_valid) begin
					@(negedge clk_fabric);
					quiet++;
				end
			end else if (row.exp_cause == DROP_NONE) begin
				wait_counter(REG_RX_OK, ok_exp);
			end else begin
				wait_counter(REG_RX_DROP, drop_exp);
				axil_read(REG_LAST_CAUSE, rd);
				check_cause(row.name, row.exp_cause, rx_drop_e'(rd[2:0]));
			end
			if (!row.hold_ready)
				wait_drain();

			axil_read(REG_RX_OK, rd);
			check_word({row.name, " rx_ok"}, ok_exp, rd);
			axil_read(REG_RX_DROP, rd);
			check_word({row.name, " rx_drop"}, drop_exp, rd);
			$display("test %-14s %s", row.name, (err_count == errs_before) ? "ok" : "has errors");
		end

		// Register readback
		errs_before = err_count;
		axil_read(REG_MAC_LO, rd);
		check_word("mac_lo", OUR_MAC[31:0], rd);
		axil_read(REG_MAC_HI, rd);
		check_word("mac_hi", {16'd0, OUR_MAC[47:32]}, rd);
		axil_read(REG_RX_DROP, rd);
		check_word("drop_total", drop_rows, rd);
		$display("test %-14s %s", "registers", (err_count == errs_before) ? "ok" : "has errors");

		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS + 1, check_count, err_count);
		if (err_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
